/* fetch_pkg.sv */
package fetch_pkg;

   // processor word, shared by instructions and program counter values
   typedef logic [15:0] word_t;

   // apb byte address and data word
   // data width follows the instruction width
   typedef logic [15:0] apb_addr_t;
   typedef logic [15:0] apb_data_t;

   // nop encoding inserted when the pipeline squashes fetch
   localparam word_t NOP_INSTR = 16'h0800;

   // read-only pc register in the apb map
   localparam apb_addr_t PC_REG_ADDR = 16'h1000;

   // control from the later pipeline stages
   typedef struct packed {
      logic hazard;
      logic squash;
      logic halt;
      logic jump;
      logic jump_reg;
      logic br_taken;
   } fetch_ctrl_t;

   // operands for target calculation
   // ext_val arrives sign extended and already shifted
   typedef struct packed {
      word_t rs_val;
      word_t ext_val;
   } fetch_opnd_t;

   // what fetch hands to decode
   typedef struct packed {
      word_t pc_2;
      word_t instr;
   } fetch_out_t;

   // apb request from the master
   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   // apb response back to the master
   typedef struct packed {
      apb_data_t prdata;
      logic      pready;
      logic      pslverr;
   } apb_rsp_t;

endpackage

/* cla_16b.sv */
`timescale 1ns/100ps

module cla_16b (
   input  fetch_pkg::word_t a,
   input  fetch_pkg::word_t b,
   input  logic             c_in,
   output fetch_pkg::word_t sum,
   output logic             c_out
);
   import fetch_pkg::*;

   // bitwise propagate and generate
   word_t      p;
   word_t      g;
   // carry into every bit position
   word_t      c;
   // group propagate and generate, one pair per nibble
   logic [3:0] gp;
   logic [3:0] gg;
   // carries into each group, gc[4] is the carry out
   logic [4:0] gc;

   assign p = a ^ b;
   assign g = a & b;

   // first level, four 4-bit lookahead groups
   for (genvar k = 0; k < 4; k++) begin : g_grp
      assign gp[k] = &p[4*k+3 -: 4];
      assign gg[k] = g[4*k+3]
                   | (p[4*k+3] & g[4*k+2])
                   | (p[4*k+3] & p[4*k+2] & g[4*k+1])
                   | (p[4*k+3] & p[4*k+2] & p[4*k+1] & g[4*k]);

      // carries inside the group from the group carry in
      assign c[4*k]   = gc[k];
      assign c[4*k+1] = g[4*k] | (p[4*k] & gc[k]);
      assign c[4*k+2] = g[4*k+1] | (p[4*k+1] & g[4*k]) | (p[4*k+1] & p[4*k] & gc[k]);
      assign c[4*k+3] = g[4*k+2] | (p[4*k+2] & g[4*k+1])
                      | (p[4*k+2] & p[4*k+1] & g[4*k])
                      | (p[4*k+2] & p[4*k+1] & p[4*k] & gc[k]);
   end

   // second level, carries into the groups
   assign gc[0] = c_in;
   assign gc[1] = gg[0] | (gp[0] & c_in);
   assign gc[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & c_in);
   assign gc[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0])
                | (gp[2] & gp[1] & gp[0] & c_in);
   assign gc[4] = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1])
                | (gp[3] & gp[2] & gp[1] & gg[0])
                | (gp[3] & gp[2] & gp[1] & gp[0] & c_in);

   assign sum   = p ^ c;
   assign c_out = gc[4];

endmodule

/* instr_mem.sv */
`timescale 1ns/100ps

module instr_mem #(
   parameter int IMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          arst_n,
   // loading port from apb
   input  logic                          wr_en,
   input  logic [$clog2(IMEM_WORDS)-1:0] wr_idx,
   input  fetch_pkg::word_t              wr_data,
   // fetch port, read at the pc
   input  logic [$clog2(IMEM_WORDS)-1:0] fetch_idx,
   output fetch_pkg::word_t              fetch_data,
   // apb read-back port
   input  logic [$clog2(IMEM_WORDS)-1:0] rd_idx,
   output fetch_pkg::word_t              rd_data
);
   import fetch_pkg::*;

   // one processor word per entry
   word_t mem [IMEM_WORDS];

   // write on the clock edge that ends the apb access
   // no loading while reset is held
   always_ff @(posedge clk) begin
      if (wr_en && arst_n) begin
         mem[wr_idx] <= wr_data;
      end
   end

   // both read ports are combinational
   // fetch sees a new word the cycle after a write lands
   assign fetch_data = mem[fetch_idx];
   assign rd_data    = mem[rd_idx];

endmodule

/* fetch.sv */
`timescale 1ns/100ps

module fetch #(
   parameter int IMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  fetch_pkg::fetch_ctrl_t        ctrl,
   input  fetch_pkg::fetch_opnd_t        opnd,
   output fetch_pkg::fetch_out_t         fout,
   output fetch_pkg::word_t              pc,
   // instruction memory loading and read-back
   input  logic                          wr_en,
   input  logic [$clog2(IMEM_WORDS)-1:0] wr_idx,
   input  fetch_pkg::word_t              wr_data,
   input  logic [$clog2(IMEM_WORDS)-1:0] rd_idx,
   output fetch_pkg::word_t              rd_data
);
   import fetch_pkg::*;

   localparam int IDX_W = $clog2(IMEM_WORDS);

   word_t             pc_q;
   word_t             next_pc;
   word_t             pc_2;
   // pc_2 plus displacement, used by branches and pc-relative jumps
   word_t             pc_rel;
   // register plus displacement for register jumps
   word_t             reg_rel;
   word_t             mem_word;
   logic              pc_en;
   logic [IDX_W-1:0]  fetch_idx;

   // sequential address
   cla_16b pc_adder (
      .a     (pc_q),
      .b     (16'd2),
      .c_in  (1'b0),
      .sum   (pc_2),
      .c_out ()
   );

   cla_16b pc_rel_adder (
      .a     (pc_2),
      .b     (opnd.ext_val),
      .c_in  (1'b0),
      .sum   (pc_rel),
      .c_out ()
   );

   cla_16b reg_rel_adder (
      .a     (opnd.rs_val),
      .b     (opnd.ext_val),
      .c_in  (1'b0),
      .sum   (reg_rel),
      .c_out ()
   );

   // hazard and halt both freeze the pc
   assign pc_en = ~(ctrl.hazard | ctrl.halt);

   // jumps win over branches, register jump over relative jump
   always_comb begin
      if (ctrl.jump) begin
         next_pc = ctrl.jump_reg ? reg_rel : pc_rel;
      end else if (ctrl.br_taken) begin
         next_pc = pc_rel;
      end else begin
         next_pc = pc_2;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc_q <= '0;
      end else if (pc_en) begin
         pc_q <= next_pc;
      end
   end

   // word index, byte bit 0 dropped, upper bits wrap the memory
   assign fetch_idx = pc_q[IDX_W:1];

   instr_mem #(
      .IMEM_WORDS (IMEM_WORDS)
   ) u_instr_mem (
      .clk        (clk),
      .arst_n     (arst_n),
      .wr_en      (wr_en),
      .wr_idx     (wr_idx),
      .wr_data    (wr_data),
      .fetch_idx  (fetch_idx),
      .fetch_data (mem_word),
      .rd_idx     (rd_idx),
      .rd_data    (rd_data)
   );

   // squash turns the fetched word into a nop
   always_comb begin
      fout.pc_2  = pc_2;
      fout.instr = ctrl.squash ? NOP_INSTR : mem_word;
   end

   assign pc = pc_q;

endmodule

/* imem_apb_slave.sv */
`timescale 1ns/100ps

module imem_apb_slave #(
   parameter int IMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  fetch_pkg::apb_req_t           apb_req,
   output fetch_pkg::apb_rsp_t           apb_rsp,
   // memory write port
   output logic                          wr_en,
   output logic [$clog2(IMEM_WORDS)-1:0] wr_idx,
   output fetch_pkg::word_t              wr_data,
   // memory read-back port
   output logic [$clog2(IMEM_WORDS)-1:0] rd_idx,
   input  fetch_pkg::word_t              rd_data,
   // live pc for the read-only register
   input  fetch_pkg::word_t              pc
);
   import fetch_pkg::*;

   localparam int          IDX_W     = $clog2(IMEM_WORDS);
   // size of the memory window in bytes
   localparam logic [16:0] MEM_BYTES = 17'(2 * IMEM_WORDS);

   logic setup;
   logic access;
   logic mem_hit;
   logic pc_hit;
   logic dec_err;
   logic pready_q;
   logic pslverr_q;

   // setup phase, psel without penable
   assign setup  = apb_req.psel & ~apb_req.penable;
   // access phase, completes on this edge since there are no wait states
   assign access = apb_req.psel & apb_req.penable;

   // address decode
   assign mem_hit = {1'b0, apb_req.paddr} < MEM_BYTES;
   assign pc_hit  = ~mem_hit & (apb_req.paddr == PC_REG_ADDR);
   // miss, or a write to the read-only pc register
   assign dec_err = ~(mem_hit | pc_hit) | (pc_hit & apb_req.pwrite);

   // response flags set during setup so they are up for the whole access cycle
   // they fall again after the access edge
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pready_q  <= 1'b0;
         pslverr_q <= 1'b0;
      end else begin
         pready_q  <= setup;
         pslverr_q <= setup & dec_err;
      end
   end

   // byte address to word index, bit 0 ignored
   assign wr_idx  = apb_req.paddr[IDX_W:1];
   assign rd_idx  = apb_req.paddr[IDX_W:1];
   assign wr_data = apb_req.pwdata;

   // only a successful memory write reaches the array
   assign wr_en = access & apb_req.pwrite & mem_hit;

   always_comb begin
      apb_rsp.pready  = pready_q;
      apb_rsp.pslverr = pslverr_q;
      // zero outside reads and on any error
      apb_rsp.prdata  = '0;
      if (access && !apb_req.pwrite && !dec_err) begin
         apb_rsp.prdata = mem_hit ? rd_data : pc;
      end
   end

endmodule

/* fetch_top.sv */
`timescale 1ns/100ps

module fetch_top #(
   parameter int IMEM_WORDS = 256
) (
   input  logic                   clk,
   input  logic                   arst_n,
   // memory loading and pc read-back
   input  fetch_pkg::apb_req_t    apb_req,
   output fetch_pkg::apb_rsp_t    apb_rsp,
   // pipeline side
   input  fetch_pkg::fetch_ctrl_t ctrl,
   input  fetch_pkg::fetch_opnd_t opnd,
   output fetch_pkg::fetch_out_t  fout
);
   import fetch_pkg::*;

   localparam int IDX_W = $clog2(IMEM_WORDS);

   // apb slave to instruction memory
   logic             wr_en;
   logic [IDX_W-1:0] wr_idx;
   word_t            wr_data;
   logic [IDX_W-1:0] rd_idx;
   word_t            rd_data;
   // current pc back to the slave
   word_t            pc;

   imem_apb_slave #(
      .IMEM_WORDS (IMEM_WORDS)
   ) u_imem_apb_slave (
      .clk     (clk),
      .arst_n  (arst_n),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .wr_en   (wr_en),
      .wr_idx  (wr_idx),
      .wr_data (wr_data),
      .rd_idx  (rd_idx),
      .rd_data (rd_data),
      .pc      (pc)
   );

   fetch #(
      .IMEM_WORDS (IMEM_WORDS)
   ) u_fetch (
      .clk     (clk),
      .arst_n  (arst_n),
      .ctrl    (ctrl),
      .opnd    (opnd),
      .fout    (fout),
      .pc      (pc),
      .wr_en   (wr_en),
      .wr_idx  (wr_idx),
      .wr_data (wr_data),
      .rd_idx  (rd_idx),
      .rd_data (rd_data)
   );

endmodule

/* tb_fetch_top.sv */
`timescale 1ns/100ps

module tb_fetch_top;
   import fetch_pkg::*;

   localparam int IMEM_WORDS = 256;
   // one apb transfer, idle edge plus setup plus access
   localparam int XFER_CYC   = 3;

   // control patterns in fetch_ctrl_t field order
   localparam logic [5:0] C_NONE = 6'b000000;
   localparam logic [5:0] C_HAZ  = 6'b100000;
   localparam logic [5:0] C_SQ   = 6'b010000;
   localparam logic [5:0] C_HALT = 6'b001000;
   localparam logic [5:0] C_JMP  = 6'b000100;
   localparam logic [5:0] C_JREG = 6'b000010;
   localparam logic [5:0] C_BR   = 6'b000001;

   logic        clk;
   logic        arst_n;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;
   fetch_ctrl_t ctrl;
   fetch_opnd_t opnd;
   fetch_out_t  fout;

   // expected memory image and program counter
   word_t model_mem [IMEM_WORDS];
   word_t model_pc;

   // fetch step table, one entry per cycle
   fetch_ctrl_t step_ctrl  [$];
   fetch_opnd_t step_opnd  [$];
   word_t       step_pc_2  [$];
   word_t       step_instr [$];
   int          step_test  [$];

   string test_name [6] = '{"reset_and_load", "sequential_fetch", "branches_and_jumps",
                            "stalls", "squash", "apb_errors_live_update"};

   int errors;
   int checks;
   int tests_run;
   int tests_failed;
   int test_err_start;
   int cycles;
   int max_cycles;

   fetch_top #(
      .IMEM_WORDS (IMEM_WORDS)
   ) uut (
      .clk     (clk),
      .arst_n  (arst_n),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .ctrl    (ctrl),
      .opnd    (opnd),
      .fout    (fout)
   );

   always #4 clk = ~clk;

   // watchdog on the whole run
   always @(posedge clk) begin
      cycles++;
      if (cycles > max_cycles) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   task automatic check_word(input word_t got, input word_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_apb(input apb_data_t got, input apb_data_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_err(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == test_err_start) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - test_err_start);
      end
      test_err_start = errors;
   endtask

   // word index the memory sees for a byte address
   function automatic int mem_index(input word_t addr);
      return int'(addr >> 1) % IMEM_WORDS;
   endfunction

   // even random value, keeps targets on instruction boundaries
   function automatic word_t rand_even();
      return word_t'($urandom) & 16'hfffe;
   endfunction

   // append one step and advance the model pc by the next-pc rule
   task automatic add_step(input int test, input logic [5:0] bits, input word_t rs,
                           input word_t ext);
      fetch_ctrl_t c;
      fetch_opnd_t o;
      word_t       seq;
      c         = fetch_ctrl_t'(bits);
      o.rs_val  = rs;
      o.ext_val = ext;
      seq       = model_pc + 16'd2;
      step_ctrl.push_back(c);
      step_opnd.push_back(o);
      step_pc_2.push_back(seq);
      step_instr.push_back(c.squash ? NOP_INSTR : model_mem[mem_index(model_pc)]);
      step_test.push_back(test);
      // stall keeps the pc, then jumps, then branch, then sequential
      if (!(c.hazard || c.halt)) begin
         if (c.jump && c.jump_reg) begin
            model_pc = rs + ext;
         end else if (c.jump || c.br_taken) begin
            model_pc = seq + ext;
         end else begin
            model_pc = seq;
         end
      end
   endtask

   task automatic build_table();
      repeat (8) add_step(1, C_NONE, '0, '0);
      add_step(2, C_BR, '0, rand_even());
      add_step(2, C_NONE, '0, '0);
      add_step(2, C_JMP, rand_even(), rand_even());
      add_step(2, C_JMP | C_JREG, rand_even(), rand_even());
      // jump_reg without jump falls through to sequential
      add_step(2, C_JREG, rand_even(), rand_even());
      // register jump beats a taken branch
      add_step(2, C_BR | C_JMP | C_JREG, rand_even(), rand_even());
      // land on 0xfffe, then step past the top of the address space
      add_step(2, C_JMP | C_JREG, 16'hfff0, 16'h000e);
      add_step(2, C_NONE, '0, '0);
      add_step(2, C_BR, '0, 16'hfff8);
      add_step(2, C_NONE, '0, '0);
      add_step(2, C_NONE, '0, '0);
      add_step(3, C_HAZ, '0, '0);
      add_step(3, C_HALT, '0, '0);
      add_step(3, C_HAZ | C_JMP, rand_even(), rand_even());
      add_step(3, C_HALT | C_BR, '0, rand_even());
      add_step(3, C_HAZ | C_HALT | C_JMP | C_JREG, rand_even(), rand_even());
      add_step(3, C_NONE, '0, '0);
      add_step(3, C_NONE, '0, '0);
      add_step(4, C_SQ, '0, '0);
      add_step(4, C_SQ | C_JMP, '0, rand_even());
      add_step(4, C_SQ | C_HAZ, '0, '0);
      add_step(4, C_SQ | C_JMP | C_JREG, rand_even(), rand_even());
      add_step(4, C_NONE, '0, '0);
   endtask

   // full transfer, response sampled mid access cycle, bus idle afterwards
   task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                           output apb_data_t rdata, output logic err);
      @(posedge clk);
      #1;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(posedge clk);
      #1;
      apb_req.penable = 1'b1;
      @(negedge clk);
      if (apb_rsp.pready !== 1'b1) begin
         errors++;
         $display("pready was not high in the access cycle to %h at %0t ns", addr, $time);
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk);
      #1;
      apb_req = '0;
   endtask

   initial begin
      apb_data_t rd;
      logic      er;
      word_t     new_word;
      int        idx;
      bit        last_row;
      void'($urandom(32'h6df546c9));
      clk            = 1'b0;
      arst_n         = 1'b0;
      apb_req        = '0;
      // pc parked at zero until the table starts
      ctrl           = fetch_ctrl_t'(C_HAZ);
      opnd           = '0;
      errors         = 0;
      checks         = 0;
      tests_run      = 0;
      tests_failed   = 0;
      test_err_start = 0;
      cycles         = 0;
      foreach (model_mem[i]) model_mem[i] = word_t'($urandom);
      model_pc = '0;
      build_table();
      max_cycles = 2 * (2 * IMEM_WORDS * XFER_CYC + step_ctrl.size()) + 100;

      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;
      check_err(apb_rsp.pslverr, 1'b0, "pslverr after reset");
      if (apb_rsp.pready !== 1'b0) begin
         errors++;
         $display("pready was not low after reset at %0t ns", $time);
      end
      apb_xfer(1'b0, PC_REG_ADDR, '0, rd, er);
      check_err(er, 1'b0, "pc register read pslverr");
      check_apb(rd, 16'h0000, "pc register after reset");
      for (int i = 0; i < IMEM_WORDS; i++) begin
         apb_xfer(1'b1, apb_addr_t'(2 * i), model_mem[i], rd, er);
         check_err(er, 1'b0, $sformatf("load word %0d pslverr", i));
      end
      for (int i = 0; i < IMEM_WORDS; i++) begin
         apb_xfer(1'b0, apb_addr_t'(2 * i), '0, rd, er);
         check_err(er, 1'b0, $sformatf("read word %0d pslverr", i));
         check_apb(rd, model_mem[i], $sformatf("read word %0d", i));
      end
      finish_test(test_name[0]);

      // one row per cycle, fout checked before the edge that applies the row
      for (int i = 0; i < step_ctrl.size(); i++) begin
         @(posedge clk);
         #1;
         ctrl = step_ctrl[i];
         opnd = step_opnd[i];
         @(negedge clk);
         check_word(fout.pc_2, step_pc_2[i], $sformatf("step %0d pc_2", i));
         check_word(fout.instr, step_instr[i], $sformatf("step %0d instr", i));
         last_row = (i == step_ctrl.size() - 1);
         if (!last_row) begin
            last_row = (step_test[i+1] != step_test[i]);
         end
         if (last_row) begin
            finish_test(test_name[step_test[i]]);
         end
      end
      // this edge applies the last row, then the pc is held again
      @(posedge clk);
      #1;
      ctrl = fetch_ctrl_t'(C_HAZ);
      opnd = '0;

      apb_xfer(1'b0, apb_addr_t'(2 * IMEM_WORDS), '0, rd, er);
      check_err(er, 1'b1, "read past memory pslverr");
      check_apb(rd, '0, "read past memory prdata");
      apb_xfer(1'b1, PC_REG_ADDR, word_t'($urandom), rd, er);
      check_err(er, 1'b1, "write to pc register pslverr");
      apb_xfer(1'b0, PC_REG_ADDR, '0, rd, er);
      check_err(er, 1'b0, "pc register read pslverr");
      check_apb(rd, model_pc, "pc register under hazard");
      // out of window write aliases word 0 if not blocked
      apb_xfer(1'b1, apb_addr_t'(2 * IMEM_WORDS), ~model_mem[0], rd, er);
      check_err(er, 1'b1, "write past memory pslverr");
      apb_xfer(1'b0, 16'h0000, '0, rd, er);
      check_apb(rd, model_mem[0], "word 0 after failed write");
      // rewrite the word under the held pc
      idx      = mem_index(model_pc);
      new_word = model_mem[idx] ^ (word_t'($urandom) | 16'h0001);
      @(negedge clk);
      check_word(fout.instr, model_mem[idx], "instr before rewrite");
      apb_xfer(1'b1, apb_addr_t'(2 * idx), new_word, rd, er);
      check_err(er, 1'b0, "rewrite pslverr");
      model_mem[idx] = new_word;
      @(negedge clk);
      check_word(fout.instr, new_word, "instr after rewrite");
      check_word(fout.pc_2, model_pc + 16'd2, "pc_2 under hazard");
      finish_test(test_name[5]);

      $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* fetch_top.f */
fetch_pkg.sv
cla_16b.sv
instr_mem.sv
fetch.sv
imem_apb_slave.sv
fetch_top.sv
tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_top

sources:
  # shared types first, then the rtl bottom up
  - fetch_pkg.sv
  - cla_16b.sv
  - instr_mem.sv
  - fetch.sv
  - imem_apb_slave.sv
  - fetch_top.sv
  - target: simulation
    files:
      - tb_fetch_top.sv
